// File: core_config.svh
// shared constants for the paddle-game glue layer
// included by the packages and RTL files that use them

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

////////////////////
// bridge byte addresses of the option words
`define CORE_ADDR_SCORE15         32'h0000_0000
`define CORE_ADDR_P2_PAD1         32'h0000_0008
`define CORE_ADDR_COIN_KEEP       32'h0000_000C
`define CORE_ADDR_DOUBLE_PADDLE   32'h0000_0014
`define CORE_ADDR_TRAINING        32'h0000_0018

////////////////////
// mclk accumulator, 74.25 MHz * step / limit gives the toggle rate
// which works out to a 12.288 MHz mclk
`define CORE_MCLK_STEP            22'd245760
`define CORE_MCLK_LIMIT           22'd742500

// sample word while the game sound line is high
`define CORE_SOUND_WORD           32'h7000_7000

// i2s frame shape
`define CORE_SLOTS_PER_CHANNEL    32
`define CORE_ACTIVE_BITS          16

`endif

// File: core_bridge_pkg.sv
// types for the host side of the core
// bridge words and the game option bits held by the settings registers

package core_bridge_pkg;

  ////////////////////
  // bridge bus

  // address and data words share one width
  typedef logic [31:0] bridge_word_t;

  ////////////////////
  // game options

  // one bit per option, each written through bit 0 of its own bridge word
  typedef struct packed {
    // game ends when a player reaches 15
    logic score_stop_at_15;
    // controller 1 no longer drives player 2
    logic disable_p2_on_pad_1;
    // coin does not restart a running game
    logic prevent_coin_reset;
    logic double_paddle_height;
    // single player against a wall
    logic training_mode;
  } game_settings_t;

endpackage

// File: core_av_pkg.sv
// types for the audio and video paths
// pixel colour, the i2s shift word and the lr slot counter

`include "core_config.svh"

package core_av_pkg;

  ////////////////////
  // video

  // 8 bits each of red, green, blue, red in the top byte
  typedef logic [23:0] rgb_t;

  ////////////////////
  // audio

  // one full i2s frame word, left half first
  typedef logic [31:0] sample_t;

  // counts sclk slots inside one lrck half
  typedef logic [$clog2(`CORE_SLOTS_PER_CHANNEL)-1:0] slot_count_t;

endpackage

// File: settings_regs.sv
// game option registers on the host bridge
// five single-bit options, each written and read back through bit 0
// of its own 32-bit word, read data valid one cycle after bridge_rd

`timescale 1ns/10ps

`include "core_config.svh"

module settings_regs
  import core_bridge_pkg::*;
(
  input  logic           clk_74a,
  input  logic           rst,
  input  bridge_word_t   bridge_addr,
  input  logic           bridge_rd,
  input  logic           bridge_wr,
  input  bridge_word_t   bridge_wr_data,
  output bridge_word_t   bridge_rd_data,
  output game_settings_t settings
);

  // coin reset is blocked out of reset, everything else off
  localparam game_settings_t SETTINGS_DEFAULT = '{
    score_stop_at_15:     1'b0,
    disable_p2_on_pad_1:  1'b0,
    prevent_coin_reset:   1'b1,
    double_paddle_height: 1'b0,
    training_mode:        1'b0
  };

  logic rd_bit;

  ////////////////////
  // write decode

  always_ff @(posedge clk_74a)
  begin
    if (rst)
    begin
      settings <= SETTINGS_DEFAULT;
    end
    else if (bridge_wr)
    begin
      // other addresses belong to the host and are ignored here
      case (bridge_addr)
        `CORE_ADDR_SCORE15:       settings.score_stop_at_15     <= bridge_wr_data[0];
        `CORE_ADDR_P2_PAD1:       settings.disable_p2_on_pad_1  <= bridge_wr_data[0];
        `CORE_ADDR_COIN_KEEP:     settings.prevent_coin_reset   <= bridge_wr_data[0];
        `CORE_ADDR_DOUBLE_PADDLE: settings.double_paddle_height <= bridge_wr_data[0];
        `CORE_ADDR_TRAINING:      settings.training_mode        <= bridge_wr_data[0];
        default:                  settings                      <= settings;
      endcase
    end
  end

  ////////////////////
  // readback

  always_comb
  begin
    case (bridge_addr)
      `CORE_ADDR_SCORE15:       rd_bit = settings.score_stop_at_15;
      `CORE_ADDR_P2_PAD1:       rd_bit = settings.disable_p2_on_pad_1;
      `CORE_ADDR_COIN_KEEP:     rd_bit = settings.prevent_coin_reset;
      `CORE_ADDR_DOUBLE_PADDLE: rd_bit = settings.double_paddle_height;
      `CORE_ADDR_TRAINING:      rd_bit = settings.training_mode;
      default:                  rd_bit = 1'b0;
    endcase
  end

  // option in bit 0, upper bits zero
  always_ff @(posedge clk_74a)
  begin
    if (bridge_rd)
    begin
      bridge_rd_data <= bridge_word_t'(rd_bit);
    end
  end

  // host never issues a read and a write in the same cycle
  a_no_rd_wr_overlap: assert property (
    @(posedge clk_74a) disable iff (rst)
    !(bridge_rd && bridge_wr)
  );

endmodule

// File: player_input_map.sv
// controller buttons to paddle controls for both players
// all outputs registered, coin is a one-cycle pulse on a start press

`timescale 1ns/10ps

module player_input_map
  import core_bridge_pkg::*;
(
  input  logic           clk_74a,
  input  logic           rst,
  input  logic [15:0]    cont1_key,
  input  logic [15:0]    cont2_key,
  input  game_settings_t settings,
  output logic           p1_up,
  output logic           p1_down,
  output logic           p1_fine,
  output logic           p2_up,
  output logic           p2_down,
  output logic           p2_fine,
  output logic           coin_insert
);

  // key bitmap positions
  localparam int unsigned KEY_UP    = 0;
  localparam int unsigned KEY_DOWN  = 1;
  localparam int unsigned KEY_B     = 5;
  localparam int unsigned KEY_X     = 6;
  localparam int unsigned KEY_L1    = 8;
  localparam int unsigned KEY_R1    = 9;
  localparam int unsigned KEY_START = 15;

  logic p2_share;
  logic start_prev;

  // pad 1 also steers player 2 unless the option turns it off
  assign p2_share = ~settings.disable_p2_on_pad_1;

  always_ff @(posedge clk_74a)
  begin
    if (rst)
    begin
      p1_up       <= 1'b0;
      p1_down     <= 1'b0;
      p1_fine     <= 1'b0;
      p2_up       <= 1'b0;
      p2_down     <= 1'b0;
      p2_fine     <= 1'b0;
      coin_insert <= 1'b0;
      start_prev  <= 1'b0;
    end
    else
    begin
      p1_up       <= cont1_key[KEY_UP];
      p1_down     <= cont1_key[KEY_DOWN];
      p1_fine     <= cont1_key[KEY_R1];
      p2_up       <= cont2_key[KEY_UP]   | (p2_share & cont1_key[KEY_X]);
      p2_down     <= cont2_key[KEY_DOWN] | (p2_share & cont1_key[KEY_B]);
      p2_fine     <= cont2_key[KEY_L1]   | (p2_share & cont1_key[KEY_R1]);
      // rising edge of start only, holding it does nothing more
      coin_insert <= cont1_key[KEY_START] & ~start_prev;
      start_prev  <= cont1_key[KEY_START];
    end
  end

  a_coin_single: assert property (
    @(posedge clk_74a) disable iff (rst)
    coin_insert |=> !coin_insert
  );

endmodule

// File: video_cleanup.sv
// conditions raw game video for the scaler in one register stage
// colour is zero outside the active area, hs and vs become one-cycle pulses

`timescale 1ns/10ps

module video_cleanup
  import core_av_pkg::*;
(
  input  logic clk_74a,
  input  logic rst,
  input  logic game_de,
  input  logic game_hs,
  input  logic game_vs,
  input  rgb_t game_rgb,
  output logic video_de,
  output logic video_hs,
  output logic video_vs,
  output rgb_t video_rgb
);

  logic hs_prev;
  logic vs_prev;

  ////////////////////
  // sync and enable

  always_ff @(posedge clk_74a)
  begin
    if (rst)
    begin
      video_de <= 1'b0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
    end
    else
    begin
      video_de <= game_de;
      // scaler wants a single clock of sync on the leading edge
      video_hs <= game_hs & ~hs_prev;
      video_vs <= game_vs & ~vs_prev;
      hs_prev  <= game_hs;
      vs_prev  <= game_vs;
    end
  end

  // colour blanked whenever de is low
  always_ff @(posedge clk_74a)
  begin
    video_rgb <= game_de ? game_rgb : '0;
  end

  a_hs_one_cycle: assert property (
    @(posedge clk_74a) disable iff (rst)
    video_hs |=> !video_hs
  );

  a_vs_one_cycle: assert property (
    @(posedge clk_74a) disable iff (rst)
    video_vs |=> !video_vs
  );

endmodule

// File: i2s_audio_gen.sv
// i2s square-wave sound generator, free-running on clk_74a
// mclk from a fractional accumulator, sclk = mclk / 4, 32 slots per lrck half
// each channel carries 16 data bits msb first and then zero fill

`timescale 1ns/10ps

`include "core_config.svh"

module i2s_audio_gen
  import core_av_pkg::*;
(
  input  logic clk_74a,
  input  logic rst,
  input  logic sound,
  output logic audio_mclk,
  output logic audio_lrck,
  output logic audio_dac
);

  localparam slot_count_t LAST_SLOT = slot_count_t'(`CORE_SLOTS_PER_CHANNEL - 1);

  logic [21:0] accum;
  logic        mclk;
  logic        mclk_tick;
  logic [1:0]  mclk_div;
  logic        sclk;
  logic        sclk_fall;
  logic        sound_meta;
  logic        sound_sync;
  slot_count_t slot_cnt;
  logic        lrck;
  logic        dac;
  sample_t     shift;

  ////////////////////
  // mclk

  // toggle whenever the accumulator has reached the limit
  assign mclk_tick = (accum >= `CORE_MCLK_LIMIT);

  always_ff @(posedge clk_74a)
  begin
    if (rst)
    begin
      accum <= '0;
      mclk  <= 1'b0;
    end
    else if (mclk_tick)
    begin
      accum <= accum - `CORE_MCLK_LIMIT + `CORE_MCLK_STEP;
      mclk  <= ~mclk;
    end
    else
    begin
      accum <= accum + `CORE_MCLK_STEP;
    end
  end

  ////////////////////
  // sclk

  // divider advances on mclk rising edges
  always_ff @(posedge clk_74a)
  begin
    if (rst)
    begin
      mclk_div <= '0;
    end
    else if (mclk_tick && !mclk)
    begin
      mclk_div <= mclk_div + 2'd1;
    end
  end

  assign sclk = mclk_div[1];

  // sclk drops when the divider wraps from 3 to 0
  assign sclk_fall = mclk_tick && !mclk && sclk && mclk_div[0];

  ////////////////////
  // frame shifter

  // game sound level into this domain
  always_ff @(posedge clk_74a)
  begin
    if (rst)
    begin
      sound_meta <= 1'b0;
      sound_sync <= 1'b0;
    end
    else
    begin
      sound_meta <= sound;
      sound_sync <= sound_meta;
    end
  end

  always_ff @(posedge clk_74a)
  begin
    if (rst)
    begin
      slot_cnt <= '0;
      lrck     <= 1'b0;
      dac      <= 1'b0;
      shift    <= '0;
    end
    else if (sclk_fall)
    begin
      dac      <= (slot_cnt < `CORE_ACTIVE_BITS) ? shift[31] : 1'b0;
      slot_cnt <= slot_cnt + 1'b1;
      if (slot_cnt == LAST_SLOT)
      begin
        lrck <= ~lrck;
        // new frame word at the end of the right channel
        if (lrck)
        begin
          shift <= sound_sync ? `CORE_SOUND_WORD : '0;
        end
      end
      else if (slot_cnt < `CORE_ACTIVE_BITS)
      begin
        shift <= {shift[30:0], 1'b0};
      end
    end
  end

  assign audio_mclk = mclk;
  assign audio_lrck = lrck;
  assign audio_dac  = dac;

  a_accum_bound: assert property (
    @(posedge clk_74a) disable iff (rst)
    accum < (`CORE_MCLK_LIMIT + `CORE_MCLK_STEP)
  );

endmodule

// File: core_top.sv
// glue layer around the paddle-game core, all on clk_74a
// holds the bridge option registers, controller mapping,
// video cleanup for the scaler and the i2s sound output

`timescale 1ns/10ps

module core_top
  import core_bridge_pkg::*, core_av_pkg::*;
(
  input  logic         clk_74a,
  input  logic         rst,

  // host bridge
  input  bridge_word_t bridge_addr,
  input  logic         bridge_rd,
  input  logic         bridge_wr,
  input  bridge_word_t bridge_wr_data,
  output bridge_word_t bridge_rd_data,

  // controllers
  input  logic [15:0]  cont1_key,
  input  logic [15:0]  cont2_key,

  // from the game
  input  logic         game_de,
  input  logic         game_hs,
  input  logic         game_vs,
  input  rgb_t         game_rgb,
  input  logic         sound,

  // to the scaler
  output logic         video_de,
  output logic         video_hs,
  output logic         video_vs,
  output rgb_t         video_rgb,

  // i2s
  output logic         audio_mclk,
  output logic         audio_lrck,
  output logic         audio_dac,

  // to the game
  output logic         p1_up,
  output logic         p1_down,
  output logic         p1_fine,
  output logic         p2_up,
  output logic         p2_down,
  output logic         p2_fine,
  output logic         coin_insert,
  output logic         score_stop_at_15,
  output logic         prevent_coin_reset,
  output logic         double_paddle_height,
  output logic         training_mode
);

  game_settings_t settings;

  settings_regs settings_regs_inst (
    .clk_74a        (clk_74a),
    .rst            (rst),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .settings       (settings)
  );

  // disable_p2_on_pad_1 only matters to the input map
  assign score_stop_at_15     = settings.score_stop_at_15;
  assign prevent_coin_reset   = settings.prevent_coin_reset;
  assign double_paddle_height = settings.double_paddle_height;
  assign training_mode        = settings.training_mode;

  player_input_map player_input_map_inst (
    .clk_74a     (clk_74a),
    .rst         (rst),
    .cont1_key   (cont1_key),
    .cont2_key   (cont2_key),
    .settings    (settings),
    .p1_up       (p1_up),
    .p1_down     (p1_down),
    .p1_fine     (p1_fine),
    .p2_up       (p2_up),
    .p2_down     (p2_down),
    .p2_fine     (p2_fine),
    .coin_insert (coin_insert)
  );

  video_cleanup video_cleanup_inst (
    .clk_74a   (clk_74a),
    .rst       (rst),
    .game_de   (game_de),
    .game_hs   (game_hs),
    .game_vs   (game_vs),
    .game_rgb  (game_rgb),
    .video_de  (video_de),
    .video_hs  (video_hs),
    .video_vs  (video_vs),
    .video_rgb (video_rgb)
  );

  i2s_audio_gen i2s_audio_gen_inst (
    .clk_74a    (clk_74a),
    .rst        (rst),
    .sound      (sound),
    .audio_mclk (audio_mclk),
    .audio_lrck (audio_lrck),
    .audio_dac  (audio_dac)
  );

endmodule

// File: core_top_tb.sv
// testbench for the paddle-game glue layer
// drives core_top through settings, controller mapping, coin, video and audio tests
// concurrent assertions compare the outputs with reference values built from the input rules

`timescale 1ns/10ps

`include "core_config.svh"

module core_top_tb;

  localparam int CLK_HALF     = 10;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 8;

  // one channel is 256 mclk toggles or about 774 cycles
  localparam int AUDIO_PHASE_CYCLES = 10400;
  localparam int MIN_AUDIO_WORDS    = 20;

  localparam int TEST_CYCLES = RESET_CYCLES + 100 + 420 + 140 + 410
                               + 3 * AUDIO_PHASE_CYCLES + 20;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES * 12 / 10;

  localparam logic [31:0] SOUND_WORD = `CORE_SOUND_WORD;
  localparam logic [31:0] LEFT_WORD  = {SOUND_WORD[31:16], 16'h0000};
  localparam logic [31:0] RIGHT_WORD = {SOUND_WORD[15:0], 16'h0000};

  // option bit order is score15 p2_pad1 coin_keep double_paddle training
  localparam logic [4:0] OPT_DEFAULT = 5'b00100;

  logic        clk_74a = 1'b0;
  logic        rst;
  logic [31:0] bridge_addr;
  logic        bridge_rd;
  logic        bridge_wr;
  logic [31:0] bridge_wr_data;
  logic [31:0] bridge_rd_data;
  logic [15:0] cont1_key;
  logic [15:0] cont2_key;
  logic        game_de;
  logic        game_hs;
  logic        game_vs;
  logic [23:0] game_rgb;
  logic        sound;
  logic        video_de;
  logic        video_hs;
  logic        video_vs;
  logic [23:0] video_rgb;
  logic        audio_mclk;
  logic        audio_lrck;
  logic        audio_dac;
  logic        p1_up;
  logic        p1_down;
  logic        p1_fine;
  logic        p2_up;
  logic        p2_down;
  logic        p2_fine;
  logic        coin_insert;
  logic        score_stop_at_15;
  logic        prevent_coin_reset;
  logic        double_paddle_height;
  logic        training_mode;

  logic [31:0] rng = 32'd30;
  string       test_name = "reset";
  int          err_count = 0;
  int          err_at_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle_count = 0;

  // reference values registered on the same edge as the DUT
  logic [4:0]  opt_ref;
  logic        rd_valid;
  logic [31:0] rd_exp;
  logic [5:0]  pad_exp;
  logic        start_q;
  logic        coin_exp;
  logic        hs_q;
  logic        vs_q;
  logic [26:0] vid_exp;
  int          addr_idx;

  // audio tracking
  logic        mclk_prev;
  logic        lrck_prev;
  logic        sound_prev;
  int          gap;
  logic        gap_valid;
  int          tog_cnt;
  logic        lr_valid;
  logic [7:0]  rise_idx;
  logic [31:0] dac_word;
  logic [31:0] word_chk;
  logic [31:0] word_exp;
  logic        word_done;
  int          skip_words;
  int          words_checked;

  logic [3:0]  opt_act;
  logic [3:0]  opt_exp;
  logic [5:0]  pad_act;
  logic [26:0] vid_act;
  logic        mclk_tog;
  logic        lrck_tog;

  always #CLK_HALF clk_74a = ~clk_74a;

  core_top core_top_inst (
    .clk_74a              (clk_74a),
    .rst                  (rst),
    .bridge_addr          (bridge_addr),
    .bridge_rd            (bridge_rd),
    .bridge_wr            (bridge_wr),
    .bridge_wr_data       (bridge_wr_data),
    .bridge_rd_data       (bridge_rd_data),
    .cont1_key            (cont1_key),
    .cont2_key            (cont2_key),
    .game_de              (game_de),
    .game_hs              (game_hs),
    .game_vs              (game_vs),
    .game_rgb             (game_rgb),
    .sound                (sound),
    .video_de             (video_de),
    .video_hs             (video_hs),
    .video_vs             (video_vs),
    .video_rgb            (video_rgb),
    .audio_mclk           (audio_mclk),
    .audio_lrck           (audio_lrck),
    .audio_dac            (audio_dac),
    .p1_up                (p1_up),
    .p1_down              (p1_down),
    .p1_fine              (p1_fine),
    .p2_up                (p2_up),
    .p2_down              (p2_down),
    .p2_fine              (p2_fine),
    .coin_insert          (coin_insert),
    .score_stop_at_15     (score_stop_at_15),
    .prevent_coin_reset   (prevent_coin_reset),
    .double_paddle_height (double_paddle_height),
    .training_mode        (training_mode)
  );

  ////////////////////
  // helpers

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // option bit for a bridge address or -1 when no option lives there
  function automatic int opt_index(input logic [31:0] addr);
    case (addr)
      `CORE_ADDR_SCORE15:       return 4;
      `CORE_ADDR_P2_PAD1:       return 3;
      `CORE_ADDR_COIN_KEEP:     return 2;
      `CORE_ADDR_DOUBLE_PADDLE: return 1;
      `CORE_ADDR_TRAINING:      return 0;
      default:                  return -1;
    endcase
  endfunction

  task automatic flag_mismatch(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    err_count = err_count + 1;
    $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
  endtask

  task automatic step(input int cycles);
    repeat (cycles)
    begin
      @(posedge clk_74a);
      #DRIVE_DELAY;
    end
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    err_at_start = err_count;
  endtask

  task automatic finish_test(input int number);
    int errs;
    // let the last responses reach the checks
    step(3);
    errs      = err_count - err_at_start;
    tests_run = tests_run + 1;
    if (errs != 0)
    begin
      tests_failed = tests_failed + 1;
    end
    $display("test %0d %s finished with %0d errors", number, test_name, errs);
  endtask

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    step(1);
    bridge_wr      = 1'b0;
  endtask

  task automatic bridge_read(input logic [31:0] addr);
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    step(1);
    bridge_rd   = 1'b0;
  endtask

  ////////////////////
  // reference model

  assign addr_idx = opt_index(bridge_addr);
  assign opt_act  = {score_stop_at_15, prevent_coin_reset, double_paddle_height, training_mode};
  assign opt_exp  = {opt_ref[4], opt_ref[2], opt_ref[1], opt_ref[0]};
  assign pad_act  = {p1_up, p1_down, p1_fine, p2_up, p2_down, p2_fine};
  assign vid_act  = {video_de, video_hs, video_vs, video_rgb};
  assign mclk_tog = (audio_mclk != mclk_prev);
  assign lrck_tog = (audio_lrck != lrck_prev);

  always @(posedge clk_74a)
  begin
    if (rst)
    begin
      opt_ref  <= OPT_DEFAULT;
      rd_valid <= 1'b0;
      rd_exp   <= '0;
      pad_exp  <= '0;
      start_q  <= 1'b0;
      coin_exp <= 1'b0;
      hs_q     <= 1'b0;
      vs_q     <= 1'b0;
      vid_exp  <= '0;
    end
    else
    begin
      if (bridge_wr && addr_idx >= 0)
      begin
        opt_ref[addr_idx] <= bridge_wr_data[0];
      end
      rd_valid <= bridge_rd;
      rd_exp   <= (addr_idx >= 0) ? {31'b0, opt_ref[addr_idx]} : 32'b0;
      // pad 1 X, B and R1 join player 2 while the share option is clear
      pad_exp  <= {cont1_key[0], cont1_key[1], cont1_key[9],
                   cont2_key[0] | (~opt_ref[3] & cont1_key[6]),
                   cont2_key[1] | (~opt_ref[3] & cont1_key[5]),
                   cont2_key[8] | (~opt_ref[3] & cont1_key[9])};
      start_q  <= cont1_key[15];
      coin_exp <= cont1_key[15] & ~start_q;
      hs_q     <= game_hs;
      vs_q     <= game_vs;
      vid_exp  <= {game_de, game_hs & ~hs_q, game_vs & ~vs_q, game_de ? game_rgb : 24'h0};
    end
  end

  ////////////////////
  // audio tracking

  always @(posedge clk_74a)
  begin
    if (rst)
    begin
      mclk_prev     <= 1'b0;
      lrck_prev     <= 1'b0;
      sound_prev    <= 1'b0;
      gap           <= 0;
      gap_valid     <= 1'b0;
      tog_cnt       <= 0;
      lr_valid      <= 1'b0;
      rise_idx      <= '0;
      dac_word      <= '0;
      word_chk      <= '0;
      word_exp      <= '0;
      word_done     <= 1'b0;
      skip_words    <= 4;
      words_checked <= 0;
    end
    else
    begin
      mclk_prev  <= audio_mclk;
      lrck_prev  <= audio_lrck;
      sound_prev <= sound;
      word_done  <= 1'b0;
      if (mclk_tog)
      begin
        gap       <= 1;
        gap_valid <= 1'b1;
        tog_cnt   <= tog_cnt + 1;
      end
      else
      begin
        gap <= gap + 1;
      end
      // lrck edge shares its cycle with mclk rise 0 of the half
      if (lrck_tog)
      begin
        tog_cnt  <= 1;
        lr_valid <= 1'b1;
        rise_idx <= '0;
      end
      else if (audio_mclk && !mclk_prev)
      begin
        rise_idx <= rise_idx + 8'd1;
        // sclk rises on the second mclk rise of each sclk period
        if (rise_idx[1:0] == 2'd1)
        begin
          dac_word <= {dac_word[30:0], audio_dac};
          // with the i2s delay bit a channel word ends one sclk into the next half
          if (rise_idx == 8'd1)
          begin
            word_chk <= {dac_word[30:0], audio_dac};
            word_exp <= sound_prev ? (audio_lrck ? LEFT_WORD : RIGHT_WORD) : 32'h0;
            if (skip_words != 0)
            begin
              skip_words <= skip_words - 1;
            end
            else
            begin
              word_done     <= 1'b1;
              words_checked <= words_checked + 1;
            end
          end
        end
      end
      // words in flight still carry the old level
      if (sound != sound_prev)
      begin
        skip_words <= 4;
      end
    end
  end

  ////////////////////
  // checks

  a_options: assert property (@(posedge clk_74a) disable iff (rst) opt_act == opt_exp)
    else flag_mismatch("option outputs", $sampled(opt_exp), $sampled(opt_act));

  a_readback: assert property (@(posedge clk_74a) disable iff (rst)
    rd_valid |-> bridge_rd_data == rd_exp)
    else flag_mismatch("bridge readback", $sampled(rd_exp), $sampled(bridge_rd_data));

  a_paddles: assert property (@(posedge clk_74a) disable iff (rst) pad_act == pad_exp)
    else flag_mismatch("paddle outputs", $sampled(pad_exp), $sampled(pad_act));

  a_coin: assert property (@(posedge clk_74a) disable iff (rst) coin_insert == coin_exp)
    else flag_mismatch("coin_insert", $sampled(coin_exp), $sampled(coin_insert));

  a_video: assert property (@(posedge clk_74a) disable iff (rst) vid_act == vid_exp)
    else flag_mismatch("video de/hs/vs/rgb", $sampled(vid_exp), $sampled(vid_act));

  a_mclk_gap: assert property (@(posedge clk_74a) disable iff (rst)
    mclk_tog && gap_valid |-> (gap == 3 || gap == 4))
    else
    begin
      err_count = err_count + 1;
      $display("[ERROR] %s mclk interval: expected 3 or 4, actual %0d", test_name,
               $sampled(gap));
    end

  a_lrck_period: assert property (@(posedge clk_74a) disable iff (rst)
    lrck_tog && lr_valid |-> tog_cnt == 256)
    else flag_mismatch("mclk toggles per lrck half", 32'd256, $sampled(tog_cnt));

  a_dac_word: assert property (@(posedge clk_74a) disable iff (rst)
    word_done |-> word_chk == word_exp)
    else flag_mismatch("dac channel word", $sampled(word_exp), $sampled(word_chk));

  ////////////////////
  // tests

  task automatic settings_test();
    logic [31:0] addrs [5];
    logic [31:0] r;
    addrs = '{`CORE_ADDR_SCORE15, `CORE_ADDR_P2_PAD1, `CORE_ADDR_COIN_KEEP,
              `CORE_ADDR_DOUBLE_PADDLE, `CORE_ADDR_TRAINING};
    start_test("settings");
    // defaults straight after reset
    foreach (addrs[i])
    begin
      bridge_read(addrs[i]);
    end
    foreach (addrs[i])
    begin
      r = next_rand();
      bridge_write(addrs[i], r | 32'h1);
      bridge_read(addrs[i]);
      bridge_write(addrs[i], r & ~32'h1);
      bridge_read(addrs[i]);
    end
    bridge_write(32'h0000_0010, 32'h1);
    bridge_read(32'h0000_0010);
    bridge_read(32'h0000_0004);
    bridge_read(32'h0000_001C);
    bridge_read(32'h0000_0100);
    finish_test(1);
  endtask

  task automatic mapping_test();
    logic [31:0] r;
    start_test("player_map");
    for (int pass = 0; pass < 2; pass++)
    begin
      bridge_write(`CORE_ADDR_P2_PAD1, pass);
      repeat (200)
      begin
        r         = next_rand();
        cont1_key = r[15:0];
        cont2_key = r[31:16];
        step(1);
      end
    end
    bridge_write(`CORE_ADDR_P2_PAD1, 32'h0);
    cont1_key = '0;
    cont2_key = '0;
    finish_test(2);
  endtask

  task automatic coin_test();
    int coins;
    coins = 0;
    start_test("coin");
    step(1);
    for (int press = 0; press < 2; press++)
    begin
      cont1_key = 16'h8000;
      repeat (50)
      begin
        step(1);
        if (coin_insert)
        begin
          coins = coins + 1;
        end
      end
      cont1_key = 16'h0000;
      repeat (10)
      begin
        step(1);
        if (coin_insert)
        begin
          coins = coins + 1;
        end
      end
    end
    assert (coins == 2)
      else flag_mismatch("coin pulse count", 32'd2, coins);
    finish_test(3);
  endtask

  task automatic video_test();
    logic [31:0] r;
    start_test("video");
    repeat (400)
    begin
      r       = next_rand();
      // mostly active with sync levels held for a random stretch
      game_de = (r[2:0] != 3'd0);
      if (r[7:4] == 4'd0)
      begin
        game_hs = ~game_hs;
      end
      if (r[11:8] == 4'd0)
      begin
        game_vs = ~game_vs;
      end
      r        = next_rand();
      game_rgb = r[23:0];
      step(1);
    end
    game_de  = 1'b0;
    game_hs  = 1'b0;
    game_vs  = 1'b0;
    game_rgb = '0;
    finish_test(4);
  endtask

  task automatic audio_test();
    int words_start;
    words_start = words_checked;
    start_test("audio");
    sound = 1'b1;
    step(AUDIO_PHASE_CYCLES);
    sound = 1'b0;
    step(AUDIO_PHASE_CYCLES);
    sound = 1'b1;
    step(AUDIO_PHASE_CYCLES);
    sound = 1'b0;
    assert (words_checked - words_start >= MIN_AUDIO_WORDS)
      else
      begin
        err_count = err_count + 1;
        $display("audio test compared only %0d channel words, too few to trust",
                 words_checked - words_start);
      end
    finish_test(5);
  endtask

  ////////////////////
  // run

  always @(posedge clk_74a)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("run stopped by the timeout after %0d cycles", cycle_count);
      $display("Errors found");
      $finish;
    end
  end

  initial
  begin
    rst            = 1'b1;
    bridge_addr    = '0;
    bridge_rd      = 1'b0;
    bridge_wr      = 1'b0;
    bridge_wr_data = '0;
    cont1_key      = '0;
    cont2_key      = '0;
    game_de        = 1'b0;
    game_hs        = 1'b0;
    game_vs        = 1'b0;
    game_rgb       = '0;
    sound          = 1'b0;
    step(RESET_CYCLES);
    rst = 1'b0;
    settings_test();
    mapping_test();
    coin_test();
    video_test();
    audio_test();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             err_count);
    if (err_count == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+.
core_bridge_pkg.sv
core_av_pkg.sv
settings_regs.sv
player_input_map.sv
video_cleanup.sv
i2s_audio_gen.sv
core_top.sv
core_top_tb.sv
